//--- include/frontend_params.svh
/*
  Fetch front end configuration
  FE_FETCH_WIDTH must be a power of two and at least 2
  FE_BTB_ENTRIES must be a power of two, indexed from PC bit 2 upward
  FE_FAQ_DEPTH must be a power of two and at least FE_FETCH_WIDTH
  FE_RESET_PC must be word aligned
*/

`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// ====================
// Fetch block geometry
// ====================
// Instruction slots per fetch block
`define FE_FETCH_WIDTH 4
// Bytes covered by one block
`define FE_BLOCK_BYTES (`FE_FETCH_WIDTH * 4)
// Slot index width inside a block
`define FE_BLOCK_OFF_W $clog2(`FE_FETCH_WIDTH)
// Count of slots, 0..FE_FETCH_WIDTH
`define FE_FETCH_CNT_W $clog2(`FE_FETCH_WIDTH + 1)

// ====================
// Queue and predictor
// ====================
// Fetch address queue entries
`define FE_FAQ_DEPTH 32
// Direct mapped BTB entries
`define FE_BTB_ENTRIES 16
`define FE_BTB_IDX_W $clog2(`FE_BTB_ENTRIES)
// First PC fetched after reset
`define FE_RESET_PC 32'h0000_1000

`endif

//--- hdl/frontend_pkg.sv
/*
  Shared types of the fetch front end
  Widths follow frontend_params.svh
  Redirect and BTB targets must be word aligned
*/

`include "frontend_params.svh"

package frontend_pkg;

  // ====================
  // Predictor handshake
  // ====================

  // Current block consumed, advance to the next one
  typedef struct packed {
    logic next;
  } bpu_req_t;

  // One fetch block, base aligned to FE_BLOCK_BYTES
  typedef struct packed {
    logic [`FE_FETCH_WIDTH-1:0] valid;
    logic [31:0]                pc;
  } bpu_rsp_t;

  // ====================
  // Back end inputs
  // ====================

  // Fetch correction, one cycle pulse
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // BTB training write, one cycle pulse
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] target;
  } btb_update_t;

  // Queued instruction address
  typedef logic [31:0] faq_addr_t;

endpackage

//--- hdl/branch_prediction_unit.sv
/*
  Fetch PC generation with a direct mapped BTB
  Every BTB hit is predicted taken, no direction counters
  Response is combinational from the PC and BTB registers
  A redirect wins over the BTB and sequential next PC
  BTB update lands on its own edge, seen by lookups one cycle later
*/

`include "frontend_params.svh"

module branch_prediction_unit (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  frontend_pkg::bpu_req_t    bpu_req_i,
  input  frontend_pkg::redirect_t   redirect_i,
  input  frontend_pkg::btb_update_t btb_update_i,
  output frontend_pkg::bpu_rsp_t    bpu_rsp_o
);

  localparam int FW     = `FE_FETCH_WIDTH;
  localparam int OFF_W  = `FE_BLOCK_OFF_W;
  localparam int IDX_W  = `FE_BTB_IDX_W;
  // Tag is everything above the index bits
  localparam int TAG_LO = IDX_W + 2;
  localparam int TAG_W  = 32 - TAG_LO;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [31:0]      target;
  } btb_entry_t;

  logic [31:0]               pc_q;
  logic [31:0]               pc_d;

  logic [`FE_BTB_ENTRIES-1:0] btb_valid_q;
  btb_entry_t                 btb_mem_q [`FE_BTB_ENTRIES];
  logic [IDX_W-1:0]           upd_idx;

  logic [31:0]               block_base;
  logic [OFF_W-1:0]          start_slot;
  logic [31:0]               slot_pc  [FW];
  logic [IDX_W-1:0]          slot_idx [FW];
  logic [FW-1:0]             slot_hit;

  logic [FW-1:0]             blk_valid;
  logic                      taken;
  logic [31:0]               taken_target;

  // ====================
  // Block and BTB lookup
  // ====================

  // Base drops the word offset, start slot keeps it
  assign block_base = {pc_q[31:OFF_W+2], {(OFF_W + 2){1'b0}}};
  assign start_slot = pc_q[OFF_W+1:2];

  // All slots looked up in parallel
  always_comb begin
    for (int i = 0; i < FW; i++) begin
      slot_pc[i]  = block_base + 32'(i * 4);
      slot_idx[i] = slot_pc[i][TAG_LO-1:2];
      slot_hit[i] = btb_valid_q[slot_idx[i]] &&
                    (btb_mem_q[slot_idx[i]].tag == slot_pc[i][31:TAG_LO]);
    end
  end

  // Valid run from start slot up to and including first hit
  always_comb begin
    taken        = 1'b0;
    taken_target = '0;
    blk_valid    = '0;
    for (int i = 0; i < FW; i++) begin
      if ((i >= int'(start_slot)) && !taken) begin
        blk_valid[i] = 1'b1;
        if (slot_hit[i]) begin
          taken        = 1'b1;
          taken_target = btb_mem_q[slot_idx[i]].target;
        end
      end
    end
  end

  assign bpu_rsp_o.valid = blk_valid;
  assign bpu_rsp_o.pc    = block_base;

  // ====================
  // Next PC
  // ====================

  // Redirect, then taken branch, then next block
  always_comb begin
    pc_d = pc_q;
    if (redirect_i.valid) begin
      pc_d = redirect_i.target;
    end else if (bpu_req_i.next) begin
      pc_d = taken ? taken_target : block_base + 32'(`FE_BLOCK_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= `FE_RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // ====================
  // BTB training
  // ====================

  assign upd_idx = btb_update_i.pc[TAG_LO-1:2];

  // Only the valid bits are cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      btb_valid_q <= '0;
    end else if (btb_update_i.valid) begin
      btb_valid_q[upd_idx] <= 1'b1;
    end
  end

  // Same index simply overwritten by a later update
  always_ff @(posedge clk) begin
    if (btb_update_i.valid) begin
      btb_mem_q[upd_idx].tag    <= btb_update_i.pc[31:TAG_LO];
      btb_mem_q[upd_idx].target <= btb_update_i.target;
    end
  end

endmodule

//--- hdl/sync_multi_channel_fifo.sv
/*
  Synchronous FIFO, several entries in and out per cycle
  payload_t must be a packed type, DEPTH a power of two
  write_num_i entries are taken from ports 0 upward
  read_num_i must not exceed the number of set read_valid_o bits
  Flush empties the FIFO and drops that cycle's write
  Written entries show on the read side one cycle later
*/

module sync_multi_channel_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 32,
  parameter int  WPORTS    = 4,
  parameter int  RPORTS    = 4
) (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             flush_i,
  // Write side
  input  logic                             write_valid_i,
  output logic                             write_ready_o,
  input  logic [$clog2(WPORTS + 1)-1:0]    write_num_i,
  input  payload_t [WPORTS-1:0]            write_data_i,
  // Read side
  output logic [RPORTS-1:0]                read_valid_o,
  input  logic [$clog2(RPORTS + 1)-1:0]    read_num_i,
  output payload_t [RPORTS-1:0]            read_data_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic             write_fire;
  logic [CNT_W-1:0] push_cnt;
  logic [CNT_W-1:0] pop_cnt;

  // ====================
  // Handshake
  // ====================

  // Ready only with room for a full set of write ports
  assign write_ready_o = (int'(count_q) + WPORTS) <= DEPTH;

  // No write on a flush edge
  assign write_fire = write_valid_i && write_ready_o && !flush_i;

  assign push_cnt = write_fire ? CNT_W'(write_num_i) : '0;
  assign pop_cnt  = CNT_W'(read_num_i);

  // ====================
  // Storage
  // ====================

  // Pointer sums wrap with the power of two depth
  always_ff @(posedge clk) begin
    for (int i = 0; i < WPORTS; i++) begin
      if (write_fire && (i < int'(write_num_i))) begin
        mem_q[wr_ptr_q + PTR_W'(i)] <= write_data_i[i];
      end
    end
  end

  // ====================
  // Pointers and count
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Pending reads thrown away too
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(push_cnt);
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop_cnt);
      count_q  <= count_q + push_cnt - pop_cnt;
    end
  end

  // ====================
  // Read ports
  // ====================

  // Thermometer valid, oldest entry on port 0
  always_comb begin
    for (int i = 0; i < RPORTS; i++) begin
      read_valid_o[i] = i < int'(count_q);
      read_data_o[i]  = mem_q[rd_ptr_q + PTR_W'(i)];
    end
  end

endmodule

//--- hdl/frontend_pipeline.sv
/*
  Fetch front end top, predictor feeding the fetch address queue
  A block is written only when the queue has room for a full block
  Consumer takes fetch_num_i addresses, at most the set valid bits
  A redirect flushes the queue on the edge it is valid
*/

`include "frontend_params.svh"

module frontend_pipeline (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  frontend_pkg::redirect_t                       redirect_i,
  input  frontend_pkg::btb_update_t                     btb_update_i,
  input  logic [`FE_FETCH_CNT_W-1:0]                    fetch_num_i,
  output logic [`FE_FETCH_WIDTH-1:0]                    fetch_valid_o,
  output frontend_pkg::faq_addr_t [`FE_FETCH_WIDTH-1:0] fetch_addr_o
);

  localparam int FW = `FE_FETCH_WIDTH;

  frontend_pkg::bpu_req_t              bpu_req;
  frontend_pkg::bpu_rsp_t              bpu_rsp;

  logic                                faq_write_ready;
  logic [`FE_FETCH_CNT_W-1:0]          faq_write_num;
  logic [`FE_BLOCK_OFF_W-1:0]          faq_first_slot;
  frontend_pkg::faq_addr_t [FW-1:0]    faq_write_data;

  // ====================
  // Predictor
  // ====================

  // Advance only when the whole block fits in the queue
  assign bpu_req.next = faq_write_ready;

  branch_prediction_unit i_branch_prediction_unit (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bpu_req_i    (bpu_req),
    .redirect_i   (redirect_i),
    .btb_update_i (btb_update_i),
    .bpu_rsp_o    (bpu_rsp)
  );

  // ====================
  // Slot expansion
  // ====================

  // Valid slots are contiguous, so pack them from port 0
  always_comb begin
    faq_write_num  = '0;
    faq_first_slot = '0;
    for (int i = FW - 1; i >= 0; i--) begin
      faq_write_num += `FE_FETCH_CNT_W'(bpu_rsp.valid[i]);
      if (bpu_rsp.valid[i]) begin
        faq_first_slot = `FE_BLOCK_OFF_W'(i);
      end
    end
    for (int j = 0; j < FW; j++) begin
      faq_write_data[j] = bpu_rsp.pc + 32'((int'(faq_first_slot) + j) * 4);
    end
  end

  // ====================
  // Fetch address queue
  // ====================

  sync_multi_channel_fifo #(
    .payload_t (frontend_pkg::faq_addr_t),
    .DEPTH     (`FE_FAQ_DEPTH),
    .WPORTS    (FW),
    .RPORTS    (FW)
  ) i_fetch_address_queue (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (redirect_i.valid),
    .write_valid_i (|bpu_rsp.valid),
    .write_ready_o (faq_write_ready),
    .write_num_i   (faq_write_num),
    .write_data_i  (faq_write_data),
    .read_valid_o  (fetch_valid_o),
    .read_num_i    (fetch_num_i),
    .read_data_o   (fetch_addr_o)
  );

endmodule

//--- test/tb_frontend.sv
/*
  Testbench for the fetch front end top level
  Address order is checked against a model, cycle timing is not
  Consumer only takes entries known to be valid one cycle ahead
  A row with a BTB update also carries a redirect to resync the model
  Model BTB indexed by PC bits 5..2, tag from bits 31..6
*/

`include "frontend_params.svh"

module tb_frontend;

  localparam int FW       = `FE_FETCH_WIDTH;
  localparam int CNT_W    = `FE_FETCH_CNT_W;
  localparam int MAX_ROWS = 8;

  // Consumer patterns
  localparam logic [1:0] TAKE_FIXED  = 2'd0;
  localparam logic [1:0] TAKE_RANDOM = 2'd1;
  localparam logic [1:0] TAKE_STALL  = 2'd2;

  // One row of the stimulus table
  typedef struct packed {
    logic        upd;
    logic [31:0] upd_pc;
    logic [31:0] upd_tgt;
    logic        redir;
    logic [31:0] redir_tgt;
    logic [1:0]  mode;
    logic [7:0]  arg;
    logic [15:0] n_check;
  } row_t;

  logic                                 clk;
  logic                                 rst_n_i;
  frontend_pkg::redirect_t              redirect_i;
  frontend_pkg::btb_update_t            btb_update_i;
  logic [CNT_W-1:0]                     fetch_num_i;
  logic [FW-1:0]                        fetch_valid_o;
  frontend_pkg::faq_addr_t [FW-1:0]     fetch_addr_o;

  row_t        rows     [MAX_ROWS];
  string       row_name [MAX_ROWS];
  int          num_rows;

  // Reference address model
  logic [31:0] model_pc;
  logic        m_valid [16];
  logic [31:0] m_pc    [16];
  logic [31:0] m_tgt   [16];

  // Consumer view, last sampled valid count and last take
  int          valid_seen;
  int          taken_prev;

  logic [31:0] lcg_state;
  int          err_count;
  int          pass_tests;
  int          fail_tests;
  int          cycle_cnt;
  int          timeout_limit;

  frontend_pipeline i_frontend_pipeline (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect_i),
    .btb_update_i  (btb_update_i),
    .fetch_num_i   (fetch_num_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_addr_o  (fetch_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles, consumer stopped making progress",
               timeout_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ====================
  // Helpers
  // ====================

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Ones counted from bit 0 up to the first zero
  function automatic int thermometer_len(input logic [FW-1:0] mask);
    int n;
    n = 0;
    for (int i = 0; i < FW; i++) begin
      if (mask[i] && (n == i)) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic train_model_btb(input logic [31:0] pc, input logic [31:0] tgt);
    int idx;
    idx = int'(pc[5:2]);
    m_valid[idx] = 1'b1;
    m_pc[idx]    = pc;
    m_tgt[idx]   = tgt;
  endtask

  // Taken on a BTB hit, else the next word
  function automatic logic [31:0] next_expected_addr();
    logic [31:0] addr;
    int          idx;
    addr = model_pc;
    idx  = int'(addr[5:2]);
    if (m_valid[idx] && (m_pc[idx][31:2] == addr[31:2])) begin
      model_pc = m_tgt[idx];
    end else begin
      model_pc = addr + 32'd4;
    end
    return addr;
  endfunction

  task automatic add_test(input string name, input logic upd, input logic [31:0] upd_pc,
                          input logic [31:0] upd_tgt, input logic redir,
                          input logic [31:0] redir_tgt, input logic [1:0] mode,
                          input int arg, input int n_check);
    rows[num_rows]     = {upd, upd_pc, upd_tgt, redir, redir_tgt, mode, 8'(arg),
                          16'(n_check)};
    row_name[num_rows] = name;
    num_rows++;
  endtask

  // Edge with no take, keeps a safe lower bound on occupancy
  task automatic drive_idle();
    @(posedge clk);
    fetch_num_i <= '0;
    valid_seen  = (valid_seen > taken_prev) ? valid_seen - taken_prev : 0;
    taken_prev  = 0;
  endtask

  // Drive a take, then check what is handed over at the next edge
  task automatic consume_step(input string name, input int req, input int limit,
                              inout int checked);
    int n;
    int run;
    n = req;
    if (n > valid_seen - taken_prev) n = valid_seen - taken_prev;
    if (n > limit - checked) n = limit - checked;
    if (n < 0) n = 0;
    @(posedge clk);
    fetch_num_i <= CNT_W'(n);
    taken_prev  = n;
    @(negedge clk);
    run = thermometer_len(fetch_valid_o);
    compare_value(name, 32'((1 << run) - 1), 32'(fetch_valid_o));
    if (n > run) begin
      compare_value(name, 32'(n), 32'(run));
    end
    for (int i = 0; i < n; i++) begin
      compare_value(name, next_expected_addr(), fetch_addr_o[i]);
      checked++;
    end
    valid_seen = run;
  endtask

  // ====================
  // One table row
  // ====================

  task automatic run_test(input int r);
    row_t  row;
    string name;
    int    checked;
    int    cyc;
    int    req;
    int    errs_before;
    row         = rows[r];
    name        = row_name[r];
    checked     = 0;
    cyc         = 0;
    errs_before = err_count;
    if (row.upd) begin
      drive_idle();
      btb_update_i <= {1'b1, row.upd_pc, row.upd_tgt};
      train_model_btb(row.upd_pc, row.upd_tgt);
    end
    if (row.redir) begin
      drive_idle();
      btb_update_i <= '0;
      redirect_i   <= {1'b1, row.redir_tgt};
      drive_idle();
      redirect_i   <= '0;
      // Queue flushed on this edge
      valid_seen = 0;
      model_pc   = row.redir_tgt;
    end else if (row.upd) begin
      drive_idle();
      btb_update_i <= '0;
    end
    while (checked < int'(row.n_check)) begin
      case (row.mode)
        TAKE_FIXED:  req = int'(row.arg);
        TAKE_RANDOM: req = int'((next_random() >> 16) % 32'd5);
        default: begin
          req = (cyc < int'(row.arg)) ? 0 : FW;
          // Long stall must leave a full queue behind
          if (cyc == int'(row.arg)) begin
            compare_value(name, 32'((1 << FW) - 1), 32'(fetch_valid_o));
          end
        end
      endcase
      consume_step(name, req, int'(row.n_check), checked);
      cyc++;
    end
    if (err_count == errs_before) begin
      $display("%-20s passed, %0d addresses in order", name, checked);
      pass_tests++;
    end else begin
      $display("%-20s failed with %0d errors", name, err_count - errs_before);
      fail_tests++;
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    rst_n_i      <= 1'b0;
    redirect_i   <= '0;
    btb_update_i <= '0;
    fetch_num_i  <= '0;
    lcg_state     = 32'h41690270;
    err_count     = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    cycle_cnt     = 0;
    num_rows      = 0;
    valid_seen    = 0;
    taken_prev    = 0;
    model_pc      = `FE_RESET_PC;
    for (int i = 0; i < 16; i++) begin
      m_valid[i] = 1'b0;
      m_pc[i]    = '0;
      m_tgt[i]   = '0;
    end

    //       name                  upd   pc          target       redir target
    add_test("reset_stream",       1'b0, 32'h0,      32'h0,      1'b0, 32'h0,
             TAKE_FIXED, 4, 40);
    add_test("random_take",        1'b0, 32'h0,      32'h0,      1'b0, 32'h0,
             TAKE_RANDOM, 0, 60);
    add_test("stall_refill",       1'b0, 32'h0,      32'h0,      1'b0, 32'h0,
             TAKE_STALL, 30, 48);
    // Word offset 2 inside its block
    add_test("redirect_unaligned", 1'b0, 32'h0,      32'h0,      1'b1, 32'h0000_8a38,
             TAKE_FIXED, 3, 24);
    add_test("btb_taken",          1'b1, 32'h2008,   32'h3004,   1'b1, 32'h0000_2000,
             TAKE_FIXED, 4, 24);
    // Same index 2 as 0x2008, other tag
    add_test("btb_replace",        1'b1, 32'h2048,   32'h5000,   1'b1, 32'h0000_2000,
             TAKE_RANDOM, 0, 32);

    timeout_limit = 0;
    for (int r = 0; r < num_rows; r++) begin
      timeout_limit += 40 * int'(rows[r].n_check);
    end

    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;

    for (int r = 0; r < num_rows; r++) begin
      run_test(r);
    end

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_tests, fail_tests,
             err_count);
    if ((fail_tests == 0) && (err_count == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hdl/frontend_pkg.sv
hdl/branch_prediction_unit.sv
hdl/sync_multi_channel_fifo.sv
hdl/frontend_pipeline.sv
test/tb_frontend.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_frontend
FILELIST = all.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the $(BUILD) build folder"

# The run passes only when the pass line shows up in the output
test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD)
